//--- rtl/exec_pkg.sv
package exec_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int op_w       = 5;

  // single-cycle ALU operations first, then the mul/div group
  localparam logic [op_w-1:0] op_add   = 5'd0;
  localparam logic [op_w-1:0] op_sub   = 5'd1;
  localparam logic [op_w-1:0] op_and   = 5'd2;
  localparam logic [op_w-1:0] op_or    = 5'd3;
  localparam logic [op_w-1:0] op_xor   = 5'd4;
  localparam logic [op_w-1:0] op_sll   = 5'd5;
  localparam logic [op_w-1:0] op_srl   = 5'd6;
  localparam logic [op_w-1:0] op_sra   = 5'd7;
  localparam logic [op_w-1:0] op_slt   = 5'd8;
  localparam logic [op_w-1:0] op_sltu  = 5'd9;
  localparam logic [op_w-1:0] op_lui   = 5'd10;
  localparam logic [op_w-1:0] op_mul   = 5'd11;
  localparam logic [op_w-1:0] op_mulhu = 5'd12;
  localparam logic [op_w-1:0] op_div   = 5'd13;
  localparam logic [op_w-1:0] op_divu  = 5'd14;
  localparam logic [op_w-1:0] op_rem   = 5'd15;
  localparam logic [op_w-1:0] op_remu  = 5'd16;

  localparam logic [op_w-1:0] op_last  = op_remu; // anything above traps

  // which execution unit finishes an operation
  localparam int unit_w = 2;
  localparam logic [unit_w-1:0] unit_alu  = 2'd0;
  localparam logic [unit_w-1:0] unit_md   = 2'd1;
  localparam logic [unit_w-1:0] unit_trap = 2'd2;

  localparam int md_cycles = 32; // one step per operand bit
  localparam int md_cnt_w  = $clog2(md_cycles);

endpackage

//--- rtl/trap_pkg.sv
package trap_pkg;

  localparam int cause_w = 4;

  // machine cause codes as in mcause
  localparam logic [cause_w-1:0] cause_none                = 4'd0;
  localparam logic [cause_w-1:0] cause_illegal_instruction = 4'd2;

endpackage

//--- rtl/register_file.sv
`timescale 1ns/100ps

module register_file (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [exec_pkg::reg_addr_w-1:0] ra1,
  input  logic [exec_pkg::reg_addr_w-1:0] ra2,
  input  logic                           we,
  input  logic [exec_pkg::reg_addr_w-1:0] wa,
  input  logic [exec_pkg::xlen-1:0]       wd,
  output logic [exec_pkg::xlen-1:0]       rd1,
  output logic [exec_pkg::xlen-1:0]       rd2
);

  logic [exec_pkg::xlen-1:0] regs [1:31]; // x0 has no storage

  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

endmodule

//--- rtl/operand_fetch_stage.sv
`timescale 1ns/100ps

module operand_fetch_stage (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            issue_valid,
  input  logic [exec_pkg::op_w-1:0]       issue_op,
  input  logic [exec_pkg::reg_addr_w-1:0] issue_rd,
  input  logic [exec_pkg::reg_addr_w-1:0] issue_rs1,
  input  logic [exec_pkg::reg_addr_w-1:0] issue_rs2,
  input  logic [exec_pkg::xlen-1:0]       issue_imm,
  input  logic                            issue_use_imm,
  input  logic [exec_pkg::xlen-1:0]       issue_pc,
  input  logic                            stall,
  input  logic                            wr_en,
  input  logic [exec_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [exec_pkg::xlen-1:0]       wr_data,
  input  logic [exec_pkg::xlen-1:0]       rf_rd1,
  input  logic [exec_pkg::xlen-1:0]       rf_rd2,
  output logic [exec_pkg::reg_addr_w-1:0] rf_ra1,
  output logic [exec_pkg::reg_addr_w-1:0] rf_ra2,
  output logic                            of_valid,
  output logic [exec_pkg::op_w-1:0]       of_op,
  output logic [exec_pkg::reg_addr_w-1:0] of_rd,
  output logic [exec_pkg::xlen-1:0]       of_a,
  output logic [exec_pkg::xlen-1:0]       of_b,
  output logic [exec_pkg::xlen-1:0]       of_imm,
  output logic [exec_pkg::xlen-1:0]       of_pc
);

  logic [exec_pkg::xlen-1:0] src_a;
  logic [exec_pkg::xlen-1:0] src_b;

  assign rf_ra1 = issue_rs1;
  assign rf_ra2 = issue_rs2;

  // the execute write lands at the same edge, so take it straight from the bus
  assign src_a = (wr_en && wr_addr == issue_rs1 && issue_rs1 != '0) ? wr_data : rf_rd1;
  assign src_b = issue_use_imm ? issue_imm :
                 (wr_en && wr_addr == issue_rs2 && issue_rs2 != '0) ? wr_data : rf_rd2;

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      of_valid <= 1'b0;
    end else if (!stall) begin
      of_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && issue_valid) begin
      of_op  <= issue_op;
      of_rd  <= issue_rd;
      of_a   <= src_a;
      of_b   <= src_b;
      of_imm <= issue_imm;
      of_pc  <= issue_pc;
    end
  end

endmodule

//--- rtl/int_alu.sv
`timescale 1ns/100ps

module int_alu (
  input  logic [exec_pkg::op_w-1:0] op,
  input  logic [exec_pkg::xlen-1:0] a,
  input  logic [exec_pkg::xlen-1:0] b,
  output logic [exec_pkg::xlen-1:0] res
);

  logic [4:0] shamt;

  assign shamt = b[4:0]; // upper bits of the shift amount are ignored

  always_comb begin
    case (op)
      exec_pkg::op_add:  res = a + b;
      exec_pkg::op_sub:  res = a - b;
      exec_pkg::op_and:  res = a & b;
      exec_pkg::op_or:   res = a | b;
      exec_pkg::op_xor:  res = a ^ b;
      exec_pkg::op_sll:  res = a << shamt;
      exec_pkg::op_srl:  res = a >> shamt;
      exec_pkg::op_sra:  res = $signed(a) >>> shamt;
      exec_pkg::op_slt: begin
        res = {{(exec_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
      end
      exec_pkg::op_sltu: begin
        res = {{(exec_pkg::xlen-1){1'b0}}, a < b};
      end
      exec_pkg::op_lui:  res = b; // immediate arrives already shifted
      default:           res = '0;
    endcase
  end

endmodule

//--- rtl/iter_muldiv.sv
`timescale 1ns/100ps

module iter_muldiv (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      md_start,
  input  logic [exec_pkg::op_w-1:0] md_op,
  input  logic [exec_pkg::xlen-1:0] md_a,
  input  logic [exec_pkg::xlen-1:0] md_b,
  output logic                      md_done,
  output logic [exec_pkg::xlen-1:0] md_result
);

  localparam int msb = exec_pkg::xlen - 1;

  logic                          running;
  logic [exec_pkg::md_cnt_w-1:0] count;
  logic [exec_pkg::op_w-1:0]     op_q;
  logic                          is_div;
  logic                          neg_q;
  logic                          neg_r;
  logic                          div_zero;
  logic                          signed_op;
  logic [exec_pkg::xlen-1:0]     abs_a;
  logic [exec_pkg::xlen-1:0]     abs_b;
  logic [exec_pkg::xlen-1:0]     a_q;
  logic [exec_pkg::xlen-1:0]     b_q;
  logic [exec_pkg::xlen-1:0]     hi;
  logic [exec_pkg::xlen-1:0]     lo;
  logic [exec_pkg::xlen:0]       add_sum;
  logic [exec_pkg::xlen+1:0]     sub_diff;

  assign signed_op = (md_op == exec_pkg::op_div) || (md_op == exec_pkg::op_rem);
  assign abs_a = (signed_op && md_a[msb]) ? -md_a : md_a;
  assign abs_b = (signed_op && md_b[msb]) ? -md_b : md_b;

  // hi holds the partial product or the remainder, lo the multiplier or quotient
  assign add_sum  = {1'b0, hi} + (lo[0] ? {1'b0, b_q} : '0);
  assign sub_diff = {1'b0, hi, lo[msb]} - {2'b0, b_q};

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      running <= 1'b0;
      count   <= '0;
      md_done <= 1'b0;
    end else begin
      md_done <= 1'b0;
      if (md_start) begin
        running <= 1'b1;
        count   <= '0;
      end else if (running) begin
        count <= count + 1'b1;
        if (count == exec_pkg::md_cycles - 1) begin
          running <= 1'b0;
          md_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (md_start) begin
      op_q     <= md_op;
      is_div   <= md_op >= exec_pkg::op_div;
      neg_q    <= signed_op && (md_a[msb] ^ md_b[msb]);
      neg_r    <= signed_op && md_a[msb];
      div_zero <= md_b == '0;
      a_q      <= md_a;
      b_q      <= abs_b;
      hi       <= '0;
      lo       <= abs_a;
    end else if (running) begin
      if (!is_div) begin
        {hi, lo} <= {add_sum, lo[msb:1]};
      end else if (!sub_diff[exec_pkg::xlen+1]) begin
        hi <= sub_diff[msb:0];
        lo <= {lo[msb-1:0], 1'b1};
      end else begin
        hi <= {hi[msb-1:0], lo[msb]};
        lo <= {lo[msb-1:0], 1'b0};
      end
    end
  end

  // min / -1 needs no special case because the negated magnitude wraps back to the dividend
  always_comb begin
    case (op_q)
      exec_pkg::op_mul:   md_result = lo;
      exec_pkg::op_mulhu: md_result = hi;
      exec_pkg::op_div,
      exec_pkg::op_divu:  md_result = div_zero ? '1 : (neg_q ? -lo : lo);
      default:            md_result = div_zero ? a_q : (neg_r ? -hi : hi);
    endcase
  end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            of_valid,
  input  logic [exec_pkg::op_w-1:0]       of_op,
  input  logic [exec_pkg::reg_addr_w-1:0] of_rd,
  input  logic [exec_pkg::xlen-1:0]       of_a,
  input  logic [exec_pkg::xlen-1:0]       of_b,
  input  logic [exec_pkg::xlen-1:0]       of_pc,
  output logic                            stall,
  output logic                            wr_en,
  output logic [exec_pkg::reg_addr_w-1:0] wr_addr,
  output logic [exec_pkg::xlen-1:0]       wr_data,
  output logic                            retire_valid,
  output logic [exec_pkg::xlen-1:0]       retire_pc,
  output logic [exec_pkg::op_w-1:0]       retire_op,
  output logic [exec_pkg::reg_addr_w-1:0] retire_rd,
  output logic [exec_pkg::xlen-1:0]       retire_wdata,
  output logic                            retire_trap,
  output logic [trap_pkg::cause_w-1:0]    retire_cause
);

  logic [exec_pkg::unit_w-1:0] unit;
  logic                        trap;
  logic                        busy;
  logic                        finish;
  logic                        md_start;
  logic                        md_done;
  logic [exec_pkg::xlen-1:0]   md_result;
  logic [exec_pkg::xlen-1:0]   alu_res;

  int_alu alu_i (
    .op  (of_op),
    .a   (of_a),
    .b   (of_b),
    .res (alu_res)
  );

  iter_muldiv muldiv_i (
    .clk       (clk),
    .rst       (rst),
    .md_start  (md_start),
    .md_op     (of_op),
    .md_a      (of_a),
    .md_b      (of_b),
    .md_done   (md_done),
    .md_result (md_result)
  );

  always_comb begin
    if (of_op > exec_pkg::op_last) begin
      unit = exec_pkg::unit_trap;
    end else if (of_op >= exec_pkg::op_mul) begin
      unit = exec_pkg::unit_md;
    end else begin
      unit = exec_pkg::unit_alu;
    end
  end

  assign trap = unit == exec_pkg::unit_trap;

  // busy keeps md_start to a single pulse while the same op sits in this stage
  assign md_start = of_valid && unit == exec_pkg::unit_md && !busy;
  assign stall    = of_valid && unit == exec_pkg::unit_md && !md_done;
  assign finish   = of_valid && !stall;

  assign wr_en   = finish && !trap && of_rd != '0;
  assign wr_addr = of_rd;
  assign wr_data = (unit == exec_pkg::unit_md) ? md_result : alu_res;

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      busy         <= 1'b0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= finish;
      if (md_start) begin
        busy <= 1'b1;
      end else if (md_done) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (finish) begin
      retire_pc    <= of_pc;
      retire_op    <= of_op;
      retire_rd    <= wr_en ? of_rd : '0;   // zero when nothing was written
      retire_wdata <= wr_en ? wr_data : '0;
      retire_trap  <= trap;
      retire_cause <= trap ? trap_pkg::cause_illegal_instruction : trap_pkg::cause_none;
    end
  end

endmodule

//--- rtl/exec_core.sv
`timescale 1ns/100ps

module exec_core (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            issue_valid,
  input  logic [exec_pkg::op_w-1:0]       issue_op,
  input  logic [exec_pkg::reg_addr_w-1:0] issue_rd,
  input  logic [exec_pkg::reg_addr_w-1:0] issue_rs1,
  input  logic [exec_pkg::reg_addr_w-1:0] issue_rs2,
  input  logic [exec_pkg::xlen-1:0]       issue_imm,
  input  logic                            issue_use_imm,
  input  logic [exec_pkg::xlen-1:0]       issue_pc,
  output logic                            stall,
  output logic                            retire_valid,
  output logic [exec_pkg::xlen-1:0]       retire_pc,
  output logic [exec_pkg::op_w-1:0]       retire_op,
  output logic [exec_pkg::reg_addr_w-1:0] retire_rd,
  output logic [exec_pkg::xlen-1:0]       retire_wdata,
  output logic                            retire_trap,
  output logic [trap_pkg::cause_w-1:0]    retire_cause
);

  logic [exec_pkg::reg_addr_w-1:0] rf_ra1;
  logic [exec_pkg::reg_addr_w-1:0] rf_ra2;
  logic [exec_pkg::xlen-1:0]       rf_rd1;
  logic [exec_pkg::xlen-1:0]       rf_rd2;
  logic                            wr_en;
  logic [exec_pkg::reg_addr_w-1:0] wr_addr;
  logic [exec_pkg::xlen-1:0]       wr_data;
  logic                            of_valid;
  logic [exec_pkg::op_w-1:0]       of_op;
  logic [exec_pkg::reg_addr_w-1:0] of_rd;
  logic [exec_pkg::xlen-1:0]       of_a;
  logic [exec_pkg::xlen-1:0]       of_b;
  logic [exec_pkg::xlen-1:0]       of_pc;

  register_file rf_i (
    .clk (clk),
    .rst (rst),
    .ra1 (rf_ra1),
    .ra2 (rf_ra2),
    .we  (wr_en),
    .wa  (wr_addr),
    .wd  (wr_data),
    .rd1 (rf_rd1),
    .rd2 (rf_rd2)
  );

  operand_fetch_stage of_i (
    .clk           (clk),
    .rst           (rst),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_rd      (issue_rd),
    .issue_rs1     (issue_rs1),
    .issue_rs2     (issue_rs2),
    .issue_imm     (issue_imm),
    .issue_use_imm (issue_use_imm),
    .issue_pc      (issue_pc),
    .stall         (stall),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .rf_rd1        (rf_rd1),
    .rf_rd2        (rf_rd2),
    .rf_ra1        (rf_ra1),
    .rf_ra2        (rf_ra2),
    .of_valid      (of_valid),
    .of_op         (of_op),
    .of_rd         (of_rd),
    .of_a          (of_a),
    .of_b          (of_b),
    .of_imm        (),              // immediate already folded into of_b
    .of_pc         (of_pc)
  );

  execute_stage ex_i (
    .clk          (clk),
    .rst          (rst),
    .of_valid     (of_valid),
    .of_op        (of_op),
    .of_rd        (of_rd),
    .of_a         (of_a),
    .of_b         (of_b),
    .of_pc        (of_pc),
    .stall        (stall),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_op    (retire_op),
    .retire_rd    (retire_rd),
    .retire_wdata (retire_wdata),
    .retire_trap  (retire_trap),
    .retire_cause (retire_cause)
  );

endmodule

//--- sim/exec_core_tb.sv
`timescale 1ns/100ps

module exec_core_tb;

  // 40 mul/div ops at full latency plus room for the single-cycle traffic
  localparam int cycle_limit = 40 * (exec_pkg::md_cycles + 3) + 600;

  logic                            clk;
  logic                            rst;
  logic                            issue_valid;
  logic [exec_pkg::op_w-1:0]       issue_op;
  logic [exec_pkg::reg_addr_w-1:0] issue_rd;
  logic [exec_pkg::reg_addr_w-1:0] issue_rs1;
  logic [exec_pkg::reg_addr_w-1:0] issue_rs2;
  logic [exec_pkg::xlen-1:0]       issue_imm;
  logic                            issue_use_imm;
  logic [exec_pkg::xlen-1:0]       issue_pc;
  logic                            stall;
  logic                            retire_valid;
  logic [exec_pkg::xlen-1:0]       retire_pc;
  logic [exec_pkg::op_w-1:0]       retire_op;
  logic [exec_pkg::reg_addr_w-1:0] retire_rd;
  logic [exec_pkg::xlen-1:0]       retire_wdata;
  logic                            retire_trap;
  logic [trap_pkg::cause_w-1:0]    retire_cause;

  int          cycles = 0;
  logic [31:0] rng_state = 32'h5f30_c55e;
  logic [31:0] next_pc;
  logic        last_was_md; // the previous accepted op went to the mul/div unit
  logic [31:0] shadow [0:31];

  // expected retirement records in program order
  logic [31:0] exp_pc_q[$];
  logic [31:0] exp_op_q[$];
  logic [31:0] exp_rd_q[$];
  logic [31:0] exp_wdata_q[$];
  logic [31:0] exp_trap_q[$];
  logic [31:0] exp_cause_q[$];
  int          exp_cycle_q[$];

  exec_core dut_i (
    .clk           (clk),
    .rst           (rst),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_rd      (issue_rd),
    .issue_rs1     (issue_rs1),
    .issue_rs2     (issue_rs2),
    .issue_imm     (issue_imm),
    .issue_use_imm (issue_use_imm),
    .issue_pc      (issue_pc),
    .stall         (stall),
    .retire_valid  (retire_valid),
    .retire_pc     (retire_pc),
    .retire_op     (retire_op),
    .retire_rd     (retire_rd),
    .retire_wdata  (retire_wdata),
    .retire_trap   (retire_trap),
    .retire_cause  (retire_cause)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] time %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      stop_on_error();
    end
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // result of one operation as the RV32 rules define it
  function automatic logic [31:0] expected_result(input logic [4:0] op, input logic [31:0] a,
                                                  input logic [31:0] b);
    logic [63:0]        prod;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic               overflow;
    prod     = {32'd0, a} * {32'd0, b};
    sa       = a;
    sb       = b;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      exec_pkg::op_add:   return a + b;
      exec_pkg::op_sub:   return a - b;
      exec_pkg::op_and:   return a & b;
      exec_pkg::op_or:    return a | b;
      exec_pkg::op_xor:   return a ^ b;
      exec_pkg::op_sll:   return a << b[4:0];
      exec_pkg::op_srl:   return a >> b[4:0];
      exec_pkg::op_sra:   return sa >>> b[4:0];
      exec_pkg::op_slt:   return (sa < sb) ? 32'd1 : 32'd0;
      exec_pkg::op_sltu:  return (a < b) ? 32'd1 : 32'd0;
      exec_pkg::op_lui:   return b;
      exec_pkg::op_mul:   return prod[31:0];
      exec_pkg::op_mulhu: return prod[63:32];
      exec_pkg::op_div: begin
        if (b == 32'd0) return 32'hffff_ffff;
        else if (overflow) return a;
        else return sa / sb;
      end
      exec_pkg::op_divu:  return (b == 32'd0) ? 32'hffff_ffff : a / b;
      exec_pkg::op_rem: begin
        if (b == 32'd0) return a;
        else if (overflow) return 32'd0;
        else return sa % sb;
      end
      exec_pkg::op_remu:  return (b == 32'd0) ? a : a % b;
      default:            return 32'd0;
    endcase
  endfunction

  // called at a rising edge, returns at the edge that captures the op
  task automatic send(input logic [4:0] op, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [4:0] rs2, input logic [31:0] imm, input logic use_imm);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        trap;
    logic        is_md;
    int          stalls;
    int          accept;
    issue_valid   <= 1'b1;
    issue_op      <= op;
    issue_rd      <= rd;
    issue_rs1     <= rs1;
    issue_rs2     <= rs2;
    issue_imm     <= imm;
    issue_use_imm <= use_imm;
    issue_pc      <= next_pc;
    stalls = 0;
    @(negedge clk);
    while (stall) begin // inputs are held until the core takes them
      stalls = stalls + 1;
      @(negedge clk);
    end
    accept = cycles + 1;
    check_value("stall_cycles", stalls, last_was_md ? exec_pkg::md_cycles + 1 : 0);
    a     = shadow[rs1];
    b     = use_imm ? imm : shadow[rs2];
    trap  = op > exec_pkg::op_last;
    is_md = !trap && op >= exec_pkg::op_mul;
    res   = expected_result(op, a, b);
    exp_pc_q.push_back(next_pc);
    exp_op_q.push_back(32'(op));
    exp_trap_q.push_back(32'(trap));
    exp_cause_q.push_back(trap ? 32'(trap_pkg::cause_illegal_instruction)
                               : 32'(trap_pkg::cause_none));
    if (trap || rd == 5'd0) begin
      exp_rd_q.push_back(32'd0);
      exp_wdata_q.push_back(32'd0);
    end else begin
      exp_rd_q.push_back(32'(rd));
      exp_wdata_q.push_back(res);
      shadow[rd] = res;
    end
    exp_cycle_q.push_back(is_md ? accept + exec_pkg::md_cycles + 2 : accept + 1);
    last_was_md = is_md;
    next_pc     = next_pc + 32'd4;
    @(posedge clk);
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    send(exec_pkg::op_lui, rd, 5'd0, 5'd0, {value[31:12], 12'd0}, 1'b1);
    send(exec_pkg::op_add, rd, rd, 5'd0, {20'd0, value[11:0]}, 1'b1);
  endtask

  task automatic drain();
    issue_valid <= 1'b0;
    last_was_md = 1'b0;
    while (exp_pc_q.size() != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  always @(negedge clk) begin
    if (rst === 1'b1 && retire_valid === 1'b1) begin
      if (exp_pc_q.size() == 0) begin
        $display("an operation retired at time %0t that was never issued", $time);
        stop_on_error();
      end else begin
        check_value("retire_pc", retire_pc, exp_pc_q.pop_front());
        check_value("retire_op", 32'(retire_op), exp_op_q.pop_front());
        check_value("retire_rd", 32'(retire_rd), exp_rd_q.pop_front());
        check_value("retire_wdata", retire_wdata, exp_wdata_q.pop_front());
        check_value("retire_trap", 32'(retire_trap), exp_trap_q.pop_front());
        check_value("retire_cause", 32'(retire_cause), exp_cause_q.pop_front());
        check_value("retire_cycle", cycles, exp_cycle_q.pop_front());
      end
    end
  end

  task automatic check_after_reset();
    @(negedge clk);
    check_value("retire_valid", 32'(retire_valid), 32'd0);
    check_value("stall", 32'(stall), 32'd0);
    @(posedge clk);
  endtask

  task automatic exercise_alu_ops();
    logic [4:0] op;
    logic [4:0] r;
    for (r = 5'd1; r <= 5'd4; r++) begin
      load_reg(r, next_rand());
    end
    load_reg(5'd5, 32'h8000_0000 | next_rand()); // negative operand for sra and slt
    for (op = exec_pkg::op_add; op <= exec_pkg::op_lui; op++) begin
      send(op, 5'd10 + op, 5'd1, 5'd2, 32'd0, 1'b0);
      send(op, 5'd21 + op, 5'd5, 5'd0, next_rand(), 1'b1);
    end
    for (r = 5'd10; r != 5'd0; r++) begin
      send(exec_pkg::op_or, 5'd6, r, 5'd0, 32'd0, 1'b0); // reads back every result
    end
    drain();
  endtask

  task automatic chain_dependent_ops();
    logic [4:0]  op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [31:0] pick;
    int          n;
    send(exec_pkg::op_add, 5'd7, 5'd1, 5'd2, 32'd0, 1'b0);
    send(exec_pkg::op_sub, 5'd7, 5'd7, 5'd3, 32'd0, 1'b0);
    send(exec_pkg::op_sll, 5'd8, 5'd7, 5'd0, next_rand(), 1'b1);
    send(exec_pkg::op_xor, 5'd7, 5'd8, 5'd7, 32'd0, 1'b0);
    for (n = 0; n < 16; n++) begin
      pick = next_rand();
      op   = 5'(pick % 32'd11);
      rd   = 5'd7 + 5'(pick[8]);
      rs1  = 5'd7 + 5'(pick[9]);
      send(op, rd, rs1, 5'd8 - 5'(pick[10]), next_rand(), pick[11]);
    end
    drain();
  endtask

  task automatic exercise_muldiv();
    logic [4:0] op;
    int         k;
    for (k = 0; k < 2; k++) begin
      load_reg(5'd1, next_rand());
      load_reg(5'd2, next_rand());
      for (op = exec_pkg::op_mul; op <= exec_pkg::op_remu; op++) begin
        send(op, 5'd10 + op - exec_pkg::op_mul, 5'd1, 5'd2, 32'd0, 1'b0);
      end
      send(exec_pkg::op_add, 5'd20, 5'd10, 5'd15, 32'd0, 1'b0);
    end
    send(exec_pkg::op_add, 5'd3, 5'd0, 5'd0, 32'd0, 1'b1);
    load_reg(5'd4, 32'h8000_0000 | next_rand());
    for (op = exec_pkg::op_div; op <= exec_pkg::op_remu; op++) begin
      send(op, 5'd16, 5'd1, 5'd3, 32'd0, 1'b0); // divide by zero
      send(op, 5'd17, 5'd4, 5'd3, 32'd0, 1'b0);
    end
    load_reg(5'd5, 32'h8000_0000);
    load_reg(5'd6, 32'hffff_ffff);
    send(exec_pkg::op_div, 5'd18, 5'd5, 5'd6, 32'd0, 1'b0);
    send(exec_pkg::op_rem, 5'd19, 5'd5, 5'd6, 32'd0, 1'b0);
    send(exec_pkg::op_divu, 5'd20, 5'd5, 5'd6, 32'd0, 1'b0);
    drain();
  endtask

  task automatic trap_and_x0_writes();
    load_reg(5'd9, next_rand());
    send(exec_pkg::op_last + 5'd1, 5'd9, 5'd1, 5'd2, 32'd0, 1'b0);
    send(5'h1f, 5'd9, 5'd1, 5'd0, next_rand(), 1'b1);
    send(exec_pkg::op_add, 5'd10, 5'd9, 5'd0, 32'd0, 1'b0); // x9 must be unchanged
    send(exec_pkg::op_add, 5'd0, 5'd1, 5'd2, 32'd0, 1'b0);
    send(exec_pkg::op_mul, 5'd0, 5'd1, 5'd2, 32'd0, 1'b0);
    send(exec_pkg::op_or, 5'd11, 5'd0, 5'd0, 32'd0, 1'b0);
    drain();
  endtask

  initial begin
    rst           = 1'b0;
    issue_valid   = 1'b0;
    issue_op      = '0;
    issue_rd      = '0;
    issue_rs1     = '0;
    issue_rs2     = '0;
    issue_imm     = '0;
    issue_use_imm = 1'b0;
    issue_pc      = '0;
    next_pc       = 32'h0000_1000;
    last_was_md   = 1'b0;
    for (int r = 0; r < 32; r++) begin
      shadow[r] = 32'd0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b1;
    check_after_reset();
    exercise_alu_ops();
    chain_dependent_ops();
    exercise_muldiv();
    trap_and_x0_writes();
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- project.f
rtl/exec_pkg.sv
rtl/trap_pkg.sv
rtl/register_file.sv
rtl/operand_fetch_stage.sv
rtl/int_alu.sv
rtl/iter_muldiv.sv
rtl/execute_stage.sv
rtl/exec_core.sv
sim/exec_core_tb.sv

//--- Bender.yml
package:
  name: exec_core

sources:
  - rtl/exec_pkg.sv
  - rtl/trap_pkg.sv
  - rtl/register_file.sv
  - rtl/operand_fetch_stage.sv
  - rtl/int_alu.sv
  - rtl/iter_muldiv.sv
  - rtl/execute_stage.sv
  - rtl/exec_core.sv
  - target: test
    files:
      - sim/exec_core_tb.sv
